//--- source/floo_cfg_pkg.sv
// ========================================
// Router configuration
// Port directions, mesh coordinates and sizing constants
// ========================================

package floo_cfg_pkg;

  // Router port indices, also the bit positions of a route mask
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  // Four mesh neighbours plus the local port
  localparam int unsigned NumPorts = 5;

  localparam int unsigned CoordWidth = 3;

  // Position of a node in the mesh
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } coord_t;

  // One-hot selection of an output port
  typedef logic [NumPorts-1:0] route_mask_t;

  // Flits buffered per input port
  localparam int unsigned FifoDepth = 4;

endpackage

//--- source/floo_flit_pkg.sv
// ========================================
// Flit format
// Head/body view of the flit word plus the last marker
// ========================================

package floo_flit_pkg;

  import floo_cfg_pkg::*;

  localparam int unsigned PayloadWidth = 16;

  // Packet tag, unique per source in flight
  localparam int unsigned TagWidth = 4;

  // Routing information carried by the head flit
  typedef struct packed {
    coord_t              dst;
    coord_t              src;
    logic [TagWidth-1:0] tag;
  } flit_hdr_t;

  // Head flits read the word as a header, body flits as raw data
  typedef union packed {
    flit_hdr_t               hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_body_u;

  // Full flit on the link
  typedef struct packed {
    logic       last;
    flit_body_u body;
  } flit_t;

endpackage

//--- source/floo_route_if.sv
// ========================================
// Routed flit stream
// Input port to crossbar, with its output mask
// ========================================

`timescale 1ns/10ps

interface floo_route_if import floo_cfg_pkg::*, floo_flit_pkg::*; ();

  logic        valid;
  logic        ready;
  flit_t       flit;
  // One-hot while valid is high
  route_mask_t route;

  // Route selector side
  modport source (
    output valid,
    output flit,
    output route,
    input  ready
  );

  // Crossbar side
  modport sink (
    input  valid,
    input  flit,
    input  route,
    output ready
  );

endinterface

//--- source/floo_input_fifo.sv
// ========================================
// Input flit FIFO
// Circular buffer with valid/ready on both sides
// ========================================

`timescale 1ns/10ps

module floo_input_fifo import floo_cfg_pkg::*, floo_flit_pkg::*; #(
  parameter int unsigned Depth = FifoDepth
) (
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  valid_i,
  output logic  ready_o,
  input  flit_t data_i,

  output logic  valid_o,
  input  logic  ready_i,
  output flit_t data_o
);

  flit_t                      mem_q [Depth];
  logic [$clog2(Depth)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;
  logic                       push, pop;

  assign ready_o = (count_q < ($clog2(Depth+1))'(Depth));
  assign valid_o = (count_q != '0);
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  // Head entry straight from storage
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ($clog2(Depth))'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ($clog2(Depth))'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the fill level
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // A flit pushed into an empty FIFO shows up at its head one cycle later
  a_push_to_head : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push && (count_q == '0) |=> valid_o && (data_o == $past(data_i))
  ) else $error("Flit pushed into an empty FIFO is not at its head");

endmodule

//--- source/floo_route_select.sv
// ========================================
// XY route selector
// Decides the output on the head flit, holds it to the last
// ========================================

`timescale 1ns/10ps

module floo_route_select import floo_cfg_pkg::*, floo_flit_pkg::*; #(
  parameter int unsigned InPort = 0
) (
  input  logic          clk_i,
  input  logic          rst_n_i,

  input  coord_t        xy_id_i,

  input  logic          valid_i,
  output logic          ready_o,
  input  flit_t         data_i,

  floo_route_if.source  route_o
);

  route_dir_e  head_dir;
  route_mask_t head_route;
  route_mask_t route_q;
  logic        is_head;
  logic        accept;

  // No stored route means the next flit opens a packet
  assign is_head = (route_q == '0);
  assign accept  = valid_i & route_o.ready;

  // Dimension-ordered decision, X first then Y
  always_comb begin
    head_dir = Eject;
    if (data_i.body.hdr.dst.x > xy_id_i.x) begin
      head_dir = East;
    end else if (data_i.body.hdr.dst.x < xy_id_i.x) begin
      head_dir = West;
    end else if (data_i.body.hdr.dst.y > xy_id_i.y) begin
      head_dir = North;
    end else if (data_i.body.hdr.dst.y < xy_id_i.y) begin
      head_dir = South;
    end
  end

  assign head_route = route_mask_t'(1) << head_dir;

  // Route kept for the body flits of a packet
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      route_q <= '0;
    end else if (accept) begin
      if (data_i.last) begin
        route_q <= '0;
      end else if (is_head) begin
        route_q <= head_route;
      end
    end
  end

  assign route_o.valid = valid_i;
  assign route_o.flit  = data_i;
  assign route_o.route = is_head ? head_route : route_q;
  assign ready_o       = route_o.ready;

  // A packet never turns back through the port it came in on
  a_no_loopback : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> $onehot(route_o.route) && !route_o.route[InPort]
  ) else $error("Route selects its own input port %0d", InPort);

  // Route held while the crossbar stalls
  a_route_hold : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_i && !route_o.ready |=> $stable(route_o.route)
  ) else $error("Route changed during a stall");

endmodule

//--- source/floo_wormhole_arbiter.sv
// ========================================
// Wormhole output arbiter
// Round-robin grant, locked for a whole packet
// ========================================

`timescale 1ns/10ps

module floo_wormhole_arbiter import floo_cfg_pkg::*, floo_flit_pkg::*; #(
  parameter int unsigned NumIn = NumPorts - 1
) (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  logic [NumIn-1:0]  valid_i,
  output logic [NumIn-1:0]  ready_o,
  input  flit_t [NumIn-1:0] data_i,

  output logic              valid_o,
  input  logic              ready_i,
  output flit_t             data_o
);

  logic [NumIn-1:0]         rr_grant, grant, lock_grant_q;
  logic [$clog2(NumIn)-1:0] prio_q;
  logic                     lock_q;
  int unsigned              win_idx;

  // First valid input at or after the priority pointer
  always_comb begin
    int unsigned idx;
    rr_grant = '0;
    for (int unsigned k = 0; k < NumIn; k++) begin
      idx = (32'(prio_q) + k) % NumIn;
      if (valid_i[idx] && (rr_grant == '0)) begin
        rr_grant[idx] = 1'b1;
      end
    end
  end

  assign grant   = lock_q ? lock_grant_q : rr_grant;
  assign ready_o = grant & {NumIn{ready_i}};

  always_comb begin
    valid_o = |(grant & valid_i);
    data_o  = '0;
    win_idx = 0;
    for (int unsigned k = 0; k < NumIn; k++) begin
      if (grant[k]) begin
        data_o  = data_i[k];
        win_idx = k;
      end
    end
  end

  // Lock on a stall or an open packet, release after the last flit
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q       <= 1'b0;
      lock_grant_q <= '0;
      prio_q       <= '0;
    end else if (valid_o) begin
      lock_q       <= !(ready_i && data_o.last);
      lock_grant_q <= grant;
      if (ready_i && data_o.last) begin
        prio_q <= ($clog2(NumIn))'((win_idx + 1) % NumIn);
      end
    end
  end

  a_grant_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant)
  ) else $error("More than one input granted");

  // Output stays put under back-pressure
  a_out_hold : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  ) else $error("Output flit changed while stalled");

endmodule

//--- source/floo_router.sv
// ========================================
// Five-port mesh router
// Input FIFOs, XY selectors and wormhole output arbiters
// ========================================

`timescale 1ns/10ps

module floo_router import floo_cfg_pkg::*, floo_flit_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  coord_t               xy_id_i,

  input  logic [NumPorts-1:0]  valid_i,
  output logic [NumPorts-1:0]  ready_o,
  input  flit_t [NumPorts-1:0] data_i,

  output logic [NumPorts-1:0]  valid_o,
  input  logic [NumPorts-1:0]  ready_i,
  output flit_t [NumPorts-1:0] data_o
);

  logic [NumPorts-1:0]        fifo_valid, fifo_ready;
  flit_t [NumPorts-1:0]       fifo_data;

  // Routed streams, seen from the crossbar
  logic [NumPorts-1:0]        in_valid, in_ready;
  flit_t [NumPorts-1:0]       in_flit;
  route_mask_t [NumPorts-1:0] in_route;

  // Per output, one slot per other input
  logic [NumPorts-1:0][NumPorts-2:0]  arb_valid, arb_ready;
  flit_t [NumPorts-1:0][NumPorts-2:0] arb_data;
  // Ready returned to each input, indexed [in][out]
  logic [NumPorts-1:0][NumPorts-1:0]  back_ready;

  for (genvar in_port = 0; in_port < NumPorts; in_port++) begin : gen_input
    floo_route_if route_if ();

    floo_input_fifo #(
      .Depth ( FifoDepth )
    ) i_input_fifo (
      .clk_i   ( clk_i               ),
      .rst_n_i ( rst_n_i             ),
      .valid_i ( valid_i[in_port]    ),
      .ready_o ( ready_o[in_port]    ),
      .data_i  ( data_i[in_port]     ),
      .valid_o ( fifo_valid[in_port] ),
      .ready_i ( fifo_ready[in_port] ),
      .data_o  ( fifo_data[in_port]  )
    );

    floo_route_select #(
      .InPort ( in_port )
    ) i_route_select (
      .clk_i   ( clk_i               ),
      .rst_n_i ( rst_n_i             ),
      .xy_id_i ( xy_id_i             ),
      .valid_i ( fifo_valid[in_port] ),
      .ready_o ( fifo_ready[in_port] ),
      .data_i  ( fifo_data[in_port]  ),
      .route_o ( route_if            )
    );

    assign in_valid[in_port] = route_if.valid;
    assign in_flit[in_port]  = route_if.flit;
    assign in_route[in_port] = route_if.route;
    assign route_if.ready    = in_ready[in_port];
  end

  // Crossbar, loopback slots left out
  for (genvar in_port = 0; in_port < NumPorts; in_port++) begin : gen_xbar_in
    for (genvar out_port = 0; out_port < NumPorts; out_port++) begin : gen_xbar_out
      if (in_port == out_port) begin : gen_loopback
        assign back_ready[in_port][out_port] = 1'b0;
      end else begin : gen_link
        assign arb_valid[out_port][in_port < out_port ? in_port : in_port - 1] =
          in_valid[in_port] & in_route[in_port][out_port];
        assign arb_data[out_port][in_port < out_port ? in_port : in_port - 1] =
          in_flit[in_port];
        assign back_ready[in_port][out_port] =
          arb_ready[out_port][in_port < out_port ? in_port : in_port - 1];
      end
    end
    assign in_ready[in_port] = |(back_ready[in_port] & in_route[in_port]);
  end

  for (genvar out_port = 0; out_port < NumPorts; out_port++) begin : gen_output
    floo_wormhole_arbiter #(
      .NumIn ( NumPorts - 1 )
    ) i_wormhole_arbiter (
      .clk_i   ( clk_i               ),
      .rst_n_i ( rst_n_i             ),
      .valid_i ( arb_valid[out_port] ),
      .ready_o ( arb_ready[out_port] ),
      .data_i  ( arb_data[out_port]  ),
      .valid_o ( valid_o[out_port]   ),
      .ready_i ( ready_i[out_port]   ),
      .data_o  ( data_o[out_port]    )
    );
  end

  // Link protocol on the router boundary
  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_assert
    a_valid_in_stable : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      valid_i[p] && !ready_o[p] |=> $stable(valid_i[p])
    ) else $error("valid_i[%0d] dropped before ready", p);

    a_valid_out_stable : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      valid_o[p] && !ready_i[p] |=> $stable(valid_o[p])
    ) else $error("valid_o[%0d] dropped before ready", p);
  end

endmodule

//--- tests/floo_router_tb.sv
// ========================================
// Router testbench
// Random packets through a router at (2,2), checked
// against an XY reference by a per-output scoreboard
// ========================================

`timescale 1ns/10ps

module floo_router_tb import floo_cfg_pkg::*, floo_flit_pkg::*;;

  // 5 tests x 200 packets x 4 flits, with a margin of 5
  localparam int unsigned TimeoutCycles = 20000;
  localparam int unsigned MaxPkts       = 512;
  localparam int unsigned MaxFlits      = 4;
  localparam coord_t      OwnXy         = '{x: 3'd2, y: 3'd2};

  logic                 clk_i;
  logic                 rst_n_i;
  logic [NumPorts-1:0]  valid_i, ready_o, valid_o, ready_i;
  flit_t [NumPorts-1:0] data_i, data_o;

  // Packet store, send lists per input, expected packet ids per output
  flit_t               pkt_mem [MaxPkts][MaxFlits];
  int unsigned         pkt_count;
  flit_t               send_q [NumPorts][$];
  int unsigned         exp_q [NumPorts][$];
  logic [TagWidth-1:0] tag_cnt [NumPorts];

  // Scoreboard state per output
  int                   open_pkt [NumPorts];
  int unsigned          flit_idx [NumPorts];
  logic [NumPorts-1:0]  held_valid;
  flit_t [NumPorts-1:0] held_data;

  logic [31:0] gen_seed, bp_seed;
  logic        bp_mode;
  int unsigned err_count, test_errs, tests_run, tests_failed, cycle_count;

  floo_router DUT (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .xy_id_i ( OwnXy   ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .data_i  ( data_i  ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i ),
    .data_o  ( data_o  )
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_step(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper half of the next state
  function automatic int unsigned rand_gen();
    gen_seed = lcg_step(gen_seed);
    return 32'(gen_seed[31:16]);
  endfunction

  // X first, then Y, local port when both match
  function automatic route_dir_e floo_ref_route(coord_t dst);
    if (dst.x > OwnXy.x) begin
      return East;
    end
    if (dst.x < OwnXy.x) begin
      return West;
    end
    if (dst.y > OwnXy.y) begin
      return North;
    end
    if (dst.y < OwnXy.y) begin
      return South;
    end
    return Eject;
  endfunction

  // Coordinate of the node behind each port
  function automatic coord_t neighbour_xy(int unsigned port);
    coord_t c;
    c = OwnXy;
    case (port)
      0: c.y = OwnXy.y + 3'd1;
      1: c.x = OwnXy.x + 3'd1;
      2: c.y = OwnXy.y - 3'd1;
      3: c.x = OwnXy.x - 3'd1;
      default: c = OwnXy;
    endcase
    return c;
  endfunction

  // Random destination that lies in the given direction
  function automatic coord_t dir_dst(int unsigned dir);
    coord_t dst;
    dst.x = CoordWidth'(rand_gen());
    dst.y = CoordWidth'(rand_gen());
    case (dir)
      0: begin
        dst.x = OwnXy.x;
        dst.y = CoordWidth'(3 + rand_gen() % 5);
      end
      1: dst.x = CoordWidth'(3 + rand_gen() % 5);
      2: begin
        dst.x = OwnXy.x;
        dst.y = CoordWidth'(rand_gen() % 2);
      end
      3: dst.x = CoordWidth'(rand_gen() % 2);
      default: dst = OwnXy;
    endcase
    return dst;
  endfunction

  // Any destination that does not lead back out of the input port
  function automatic coord_t random_dst(int unsigned port);
    coord_t dst;
    do begin
      dst.x = CoordWidth'(rand_gen());
      dst.y = CoordWidth'(rand_gen());
    end while (32'(floo_ref_route(dst)) == port);
    return dst;
  endfunction

  task automatic make_packet(int unsigned port, coord_t dst, int unsigned len);
    int unsigned id;
    flit_t       f;
    id = pkt_count;
    pkt_count++;
    for (int unsigned i = 0; i < len; i++) begin
      f.last = (i == len - 1);
      if (i == 0) begin
        f.body.hdr.dst = dst;
        f.body.hdr.src = neighbour_xy(port);
        f.body.hdr.tag = tag_cnt[port];
      end else begin
        f.body.payload = PayloadWidth'(rand_gen());
      end
      pkt_mem[id][i] = f;
      send_q[port].push_back(f);
    end
    tag_cnt[port] = tag_cnt[port] + 1'b1;
    exp_q[floo_ref_route(dst)].push_back(id);
  endtask

  task automatic random_packets(int unsigned num);
    int unsigned port;
    for (int unsigned n = 0; n < num; n++) begin
      port = rand_gen() % NumPorts;
      make_packet(port, random_dst(port), 1 + rand_gen() % MaxFlits);
    end
  endtask

  // Wait until every flit was sent and every expected packet seen
  task automatic wait_drained();
    logic busy;
    do begin
      @(negedge clk_i);
      busy = (valid_i != '0);
      for (int p = 0; p < NumPorts; p++) begin
        if (send_q[p].size() != 0 || exp_q[p].size() != 0 || open_pkt[p] >= 0) begin
          busy = 1'b1;
        end
      end
    end while (busy);
  endtask

  task automatic report_test(string name);
    tests_run++;
    if (err_count == test_errs) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, err_count - test_errs);
      tests_failed++;
    end
    test_errs = err_count;
  endtask

  // Input drivers, a flit leaves its send list on a handshake
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_i <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (valid_i[p] && ready_o[p]) begin
          void'(send_q[p].pop_front());
        end
        if (send_q[p].size() != 0) begin
          valid_i[p] <= 1'b1;
          data_i[p]  <= send_q[p][0];
        end else begin
          valid_i[p] <= 1'b0;
        end
      end
    end
  end

  // Output back-pressure, each port ready about three cycles in four
  always @(posedge clk_i) begin
    if (bp_mode) begin
      bp_seed = lcg_step(bp_seed);
      ready_i <= bp_seed[31:27] | bp_seed[26:22];
    end else begin
      ready_i <= '1;
    end
  end

  // Scoreboard
  always @(posedge clk_i) begin
    int    id;
    int    hit;
    flit_t exp_flit;
    for (int o = 0; o < NumPorts; o++) begin
      if (!rst_n_i) begin
        open_pkt[o]   = -1;
        held_valid[o] = 1'b0;
      end else begin
        if (held_valid[o] && (!valid_o[o] || data_o[o] !== held_data[o])) begin
          $display("CHECK FAILED: data_o[%0d] stalled at %h, now %h with valid_o %h",
                   o, held_data[o], data_o[o], valid_o[o]);
          err_count++;
        end
        if (valid_o[o] && ready_i[o] && open_pkt[o] < 0) begin
          // Head flit, look up its packet by source and tag
          id  = -1;
          hit = -1;
          for (int i = 0; i < exp_q[o].size(); i++) begin
            if (hit < 0 &&
                pkt_mem[exp_q[o][i]][0].body.hdr.src == data_o[o].body.hdr.src &&
                pkt_mem[exp_q[o][i]][0].body.hdr.tag == data_o[o].body.hdr.tag) begin
              hit = i;
            end
          end
          if (hit < 0) begin
            $display("Unexpected head flit %h on output port %0d", data_o[o], o);
            err_count++;
          end else begin
            id = int'(exp_q[o][hit]);
            exp_q[o].delete(hit);
            open_pkt[o] = id;
            flit_idx[o] = 0;
          end
        end
        if (valid_o[o] && ready_i[o] && open_pkt[o] >= 0) begin
          exp_flit = pkt_mem[open_pkt[o]][flit_idx[o]];
          if (data_o[o] !== exp_flit) begin
            $display("CHECK FAILED: data_o[%0d] expected %h, got %h", o, exp_flit, data_o[o]);
            err_count++;
          end
          flit_idx[o]++;
          if (data_o[o].last || exp_flit.last) begin
            open_pkt[o] = -1;
          end
        end
        held_valid[o] = valid_o[o] && !ready_i[o];
        held_data[o]  = data_o[o];
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: traffic did not drain within %0d cycles", TimeoutCycles);
    $display("test failed");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    valid_i      = '0;
    data_i       = '0;
    ready_i      = '1;
    bp_mode      = 1'b0;
    gen_seed     = 32'd83164;
    bp_seed      = 32'd83164;
    pkt_count    = 0;
    err_count    = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int p = 0; p < NumPorts; p++) begin
      tag_cnt[p]  = '0;
      open_pkt[p] = -1;
    end
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    @(posedge clk_i);
    if (valid_o !== '0) begin
      $display("CHECK FAILED: valid_o expected %h, got %h", 5'h00, valid_o);
      err_count++;
    end
    if (ready_o !== '1) begin
      $display("CHECK FAILED: ready_o expected %h, got %h", 5'h1f, ready_o);
      err_count++;
    end
    report_test("reset state");

    for (int p = 0; p < NumPorts; p++) begin
      for (int d = 0; d < NumPorts; d++) begin
        if (d != p) begin
          @(negedge clk_i);
          make_packet(p, dir_dst(d), 1 + rand_gen() % MaxFlits);
          wait_drained();
        end
      end
    end
    report_test("single packets");

    // Hot spots on East and West, full-length packets from all other inputs
    @(negedge clk_i);
    for (int n = 0; n < 3; n++) begin
      for (int t = 1; t < NumPorts; t += 2) begin
        for (int p = 0; p < NumPorts; p++) begin
          if (p != t) begin
            make_packet(p, dir_dst(t), MaxFlits);
          end
        end
      end
    end
    wait_drained();
    report_test("wormhole contention");

    @(negedge clk_i);
    bp_mode = 1'b1;
    random_packets(60);
    wait_drained();
    bp_mode = 1'b0;
    report_test("back-pressure");

    @(negedge clk_i);
    random_packets(200);
    wait_drained();
    if (valid_o !== '0) begin
      $display("CHECK FAILED: valid_o expected %h after drain, got %h", 5'h00, valid_o);
      err_count++;
    end
    report_test("random traffic");

    $display("Summary: %0d tests clean, %0d with errors, %0d errors total",
             tests_run - tests_failed, tests_failed, err_count);
    if (tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
source/floo_cfg_pkg.sv
source/floo_flit_pkg.sv
source/floo_route_if.sv
source/floo_input_fifo.sv
source/floo_route_select.sv
source/floo_wormhole_arbiter.sv
source/floo_router.sv
tests/floo_router_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module floo_router_tb -o floo_router_sim

out=$(./obj_dir/floo_router_sim) || true
echo "$out"
echo "$out" | grep -qx "test passed"
